// File: src/rackbus_pkg.sv
package rackbus_pkg;

    // command word width, repeated every frame of 8 sysclk cycles
    localparam int CMD_BITS = 32;

    // single bit positions
    localparam int IGNORE_BIT     = 31;
    localparam int PPS_BIT        = 30;
    localparam int TRIG_VALID_BIT = 17;

    // field base positions
    localparam int RUNCMD_LSB    = 28;
    localparam int MODE1TYPE_LSB = 26;
    localparam int MODE1DATA_LSB = 18;
    localparam int TRIG_LSB      = 0;

    // field widths
    // bits 16:15 sit between trigger and trigger valid and stay zero
    localparam int RUNCMD_BITS    = 2;
    localparam int MODE1TYPE_BITS = 2;
    localparam int MODE1DATA_BITS = 8;
    localparam int TRIG_BITS      = 15;

    // word and field types
    typedef logic [CMD_BITS-1:0]       cmd_word_t;
    typedef logic [RUNCMD_BITS-1:0]    runcmd_t;
    typedef logic [MODE1TYPE_BITS-1:0] mode1type_t;
    typedef logic [MODE1DATA_BITS-1:0] mode1data_t;
    typedef logic [TRIG_BITS-1:0]      trig_t;

    // run command codes
    localparam runcmd_t RUNCMD_NOOP = 2'd0;

    // mode1 type codes
    // special carries noop or the fw marks, fwu carries a firmware byte
    localparam mode1type_t MODE1_SPECIAL = 2'd0;
    localparam mode1type_t MODE1_FWU     = 2'd1;

    // mode1 data codes, meaningful with the special type
    localparam mode1data_t MODE1_NOOP      = 8'h00;
    localparam mode1data_t MODE1_MARK0_FWU = 8'h01;
    localparam mode1data_t MODE1_MARK1_FWU = 8'h02;

    // frame phase counter
    localparam int PHASE_BITS = 3;

    // phase value right after a sync edge
    localparam logic [PHASE_BITS-1:0] PHASE_AFTER_SYNC = 3'd1;

    // strobes are registered, so each fires one cycle after its phase
    // precapture latches candidates, capture samples the free flags
    localparam logic [PHASE_BITS-1:0] PRECAPTURE_PHASE = 3'd5;
    localparam logic [PHASE_BITS-1:0] CAPTURE_PHASE    = 3'd6;

endpackage

// File: src/cmd_phase_gen.sv
`timescale 1ns/1ps

module cmd_phase_gen (
    input  logic sysclk_i,
    input  logic rst_i,
    input  logic sync_i,
    output logic precapture_o,
    output logic capture_o
);

    // position inside the 8 cycle command frame
    logic [rackbus_pkg::PHASE_BITS-1:0] phase;

    always_ff @(posedge sysclk_i) begin
        if (rst_i) begin
            phase        <= '0;
            precapture_o <= 1'b0;
            capture_o    <= 1'b0;
        end else begin
            // sync re-aligns the frame, otherwise wrap modulo 8
            if (sync_i) begin
                phase <= rackbus_pkg::PHASE_AFTER_SYNC;
            end else begin
                phase <= phase + 1'b1;
            end
            // strobes lag their phase value by one cycle
            precapture_o <= (phase == rackbus_pkg::PRECAPTURE_PHASE);
            capture_o    <= (phase == rackbus_pkg::CAPTURE_PHASE);
        end
    end

endmodule

// File: src/mode1_holder.sv
`timescale 1ns/1ps

module mode1_holder (
    input  logic                    sysclk_i,
    input  logic                    rst_i,
    input  logic                    precapture_i,
    input  logic                    capture_i,
    input  logic                    mode1_free_i,
    input  rackbus_pkg::mode1data_t mode1_tdata_i,
    input  rackbus_pkg::mode1type_t mode1_tuser_i,
    input  logic                    mode1_tvalid_i,
    input  rackbus_pkg::mode1data_t fw_tdata_i,
    input  logic                    fw_tvalid_i,
    input  logic [1:0]              fw_mark_i,
    output logic                    mode1_tready_o,
    output logic                    fw_tready_o,
    output logic                    fw_marked_o,
    output rackbus_pkg::mode1data_t mode1data_o,
    output rackbus_pkg::mode1type_t mode1type_o,
    output logic                    holding_o
);

    // which source the holding register was loaded from
    logic holding_mode1;
    logic holding_mark;
    logic holding_fwu;

    // candidate for the next frame
    rackbus_pkg::mode1data_t next_data;
    rackbus_pkg::mode1type_t next_type;

    // priority: mode1 stream, mark0, mark1, fw byte, noop
    always_comb begin
        if (mode1_tvalid_i) begin
            next_data = mode1_tdata_i;
            next_type = mode1_tuser_i;
        end else if (fw_mark_i[0]) begin
            next_data = rackbus_pkg::MODE1_MARK0_FWU;
            next_type = rackbus_pkg::MODE1_SPECIAL;
        end else if (fw_mark_i[1]) begin
            next_data = rackbus_pkg::MODE1_MARK1_FWU;
            next_type = rackbus_pkg::MODE1_SPECIAL;
        end else if (fw_tvalid_i) begin
            next_data = fw_tdata_i;
            next_type = rackbus_pkg::MODE1_FWU;
        end else begin
            next_data = rackbus_pkg::MODE1_NOOP;
            next_type = rackbus_pkg::MODE1_SPECIAL;
        end
    end

    // payload is reloaded every frame, even when it goes unused
    always_ff @(posedge sysclk_i) begin
        if (precapture_i) begin
            mode1data_o <= next_data;
            mode1type_o <= next_type;
        end
    end

    always_ff @(posedge sysclk_i) begin
        if (rst_i) begin
            holding_mode1  <= 1'b0;
            holding_mark   <= 1'b0;
            holding_fwu    <= 1'b0;
            mode1_tready_o <= 1'b0;
            fw_tready_o    <= 1'b0;
            fw_marked_o    <= 1'b0;
        end else begin
            if (precapture_i) begin
                holding_mode1 <= mode1_tvalid_i;
                // one flag covers both marks so only one ack goes out
                holding_mark  <= (|fw_mark_i) && !mode1_tvalid_i;
                holding_fwu   <= fw_tvalid_i && (fw_mark_i == 2'b00) && !mode1_tvalid_i;
            end
            // ack only the held source, and only if the field was empty
            // a lost item is simply recaptured next frame
            mode1_tready_o <= capture_i && holding_mode1 && mode1_free_i;
            fw_marked_o    <= capture_i && holding_mark && mode1_free_i;
            fw_tready_o    <= capture_i && holding_fwu && mode1_free_i;
        end
    end

    // noop/special filler does not count as local data
    assign holding_o = holding_mode1 || holding_mark || holding_fwu;

endmodule

// File: src/slot_holder.sv
`timescale 1ns/1ps

module slot_holder #(
    parameter type      payload_t  = logic [7:0],
    parameter payload_t idle_value = '0
) (
    input  logic     sysclk_i,
    input  logic     rst_i,
    input  logic     precapture_i,
    input  logic     capture_i,
    input  logic     free_i,
    input  payload_t tdata_i,
    input  logic     tvalid_i,
    output logic     tready_o,
    output payload_t held_o,
    output logic     holding_o
);

    // idle value keeps the field harmless when nothing is pending
    always_ff @(posedge sysclk_i) begin
        if (precapture_i) begin
            held_o <= tvalid_i ? tdata_i : idle_value;
        end
    end

    always_ff @(posedge sysclk_i) begin
        if (rst_i) begin
            holding_o <= 1'b0;
            tready_o  <= 1'b0;
        end else begin
            if (precapture_i) begin
                holding_o <= tvalid_i;
            end
            // single cycle ready once the item really went out
            tready_o <= capture_i && holding_o && free_i;
        end
    end

endmodule

// File: src/cmd_splice.sv
`timescale 1ns/1ps

module cmd_splice (
    input  logic                    sysclk_i,
    input  logic                    rst_i,
    input  logic                    capture_i,
    input  rackbus_pkg::cmd_word_t  command_i,
    input  logic                    command_locked_i,
    input  rackbus_pkg::mode1data_t mode1data_i,
    input  rackbus_pkg::mode1type_t mode1type_i,
    input  logic                    mode1_holding_i,
    input  rackbus_pkg::runcmd_t    runcmd_i,
    input  logic                    runcmd_holding_i,
    input  rackbus_pkg::trig_t      trig_i,
    input  logic                    trig_holding_i,
    input  logic                    tfio_pps_i,
    input  logic                    use_tfio_pps_i,
    output logic                    mode1_free_o,
    output logic                    runcmd_free_o,
    output logic                    trig_free_o,
    output rackbus_pkg::cmd_word_t  spliced_o
);

    // turf word fields
    logic                    turf_ignore;
    logic                    turf_pps;
    rackbus_pkg::runcmd_t    turf_runcmd;
    rackbus_pkg::mode1type_t turf_mode1type;
    rackbus_pkg::mode1data_t turf_mode1data;
    logic                    turf_trig_valid;
    rackbus_pkg::trig_t      turf_trig;

    // local pps seen since the last capture
    logic pps_seen;
    logic tfio_pps;
    logic turf_unusable;
    logic local_data;

    assign turf_ignore     = command_i[rackbus_pkg::IGNORE_BIT];
    assign turf_pps        = command_i[rackbus_pkg::PPS_BIT];
    assign turf_runcmd     = command_i[rackbus_pkg::RUNCMD_LSB +: rackbus_pkg::RUNCMD_BITS];
    assign turf_mode1type  = command_i[rackbus_pkg::MODE1TYPE_LSB +: rackbus_pkg::MODE1TYPE_BITS];
    assign turf_mode1data  = command_i[rackbus_pkg::MODE1DATA_LSB +: rackbus_pkg::MODE1DATA_BITS];
    assign turf_trig_valid = command_i[rackbus_pkg::TRIG_VALID_BIT];
    assign turf_trig       = command_i[rackbus_pkg::TRIG_LSB +: rackbus_pkg::TRIG_BITS];

    // unlocked link or ignore means nothing above the trigger is valid
    assign turf_unusable = turf_ignore || !command_locked_i;

    // mode1 is empty when the turf sends special/noop
    assign mode1_free_o  = turf_unusable ||
                           ((turf_mode1type == rackbus_pkg::MODE1_SPECIAL) &&
                            (turf_mode1data == rackbus_pkg::MODE1_NOOP));
    assign runcmd_free_o = turf_unusable || (turf_runcmd == rackbus_pkg::RUNCMD_NOOP);
    // trigger half has its own valid bit, ignore does not cover it
    assign trig_free_o   = !command_locked_i || !turf_trig_valid;

    always_ff @(posedge sysclk_i) begin
        if (rst_i) begin
            pps_seen <= 1'b0;
        end else if (capture_i) begin
            pps_seen <= 1'b0;
        end else if (tfio_pps_i) begin
            pps_seen <= 1'b1;
        end
    end

    assign tfio_pps = tfio_pps_i || pps_seen;

    // pending local pps also counts as something to send
    assign local_data = mode1_holding_i || runcmd_holding_i || trig_holding_i ||
                        (use_tfio_pps_i && tfio_pps);

    always_comb begin
        // reserved bits stay zero
        spliced_o = '0;
        spliced_o[rackbus_pkg::IGNORE_BIT] = turf_unusable && !local_data;
        if (use_tfio_pps_i) begin
            spliced_o[rackbus_pkg::PPS_BIT] = tfio_pps;
        end else begin
            spliced_o[rackbus_pkg::PPS_BIT] = turf_pps && !turf_unusable;
        end
        spliced_o[rackbus_pkg::RUNCMD_LSB +: rackbus_pkg::RUNCMD_BITS] =
            runcmd_free_o ? runcmd_i : turf_runcmd;
        spliced_o[rackbus_pkg::MODE1TYPE_LSB +: rackbus_pkg::MODE1TYPE_BITS] =
            mode1_free_o ? mode1type_i : turf_mode1type;
        spliced_o[rackbus_pkg::MODE1DATA_LSB +: rackbus_pkg::MODE1DATA_BITS] =
            mode1_free_o ? mode1data_i : turf_mode1data;
        spliced_o[rackbus_pkg::TRIG_VALID_BIT] = trig_free_o ? trig_holding_i : turf_trig_valid;
        spliced_o[rackbus_pkg::TRIG_LSB +: rackbus_pkg::TRIG_BITS] =
            trig_free_o ? trig_i : turf_trig;
    end

endmodule

// File: src/turfio_cmd_top.sv
`timescale 1ns/1ps

module turfio_cmd_top (
    input  logic                    sysclk_i,
    input  logic                    rst_i,
    input  logic                    sync_i,
    input  rackbus_pkg::cmd_word_t  command_i,
    input  logic                    command_locked_i,
    // addressed mode1 stream, tdest is not decoded here
    input  rackbus_pkg::mode1data_t mode1_tdata_i,
    input  rackbus_pkg::mode1type_t mode1_tuser_i,
    input  logic [2:0]              mode1_tdest_i,
    input  logic                    mode1_tvalid_i,
    output logic                    mode1_tready_o,
    // firmware upload bytes and marks
    input  rackbus_pkg::mode1data_t tfio_fw_tdata_i,
    input  logic                    tfio_fw_tvalid_i,
    output logic                    tfio_fw_tready_o,
    input  logic [1:0]              tfio_fw_mark_i,
    output logic                    tfio_fw_marked_o,
    input  rackbus_pkg::runcmd_t    tfio_runcmd_tdata_i,
    input  logic                    tfio_runcmd_tvalid_i,
    output logic                    tfio_runcmd_tready_o,
    input  rackbus_pkg::trig_t      tfio_trig_tdata_i,
    input  logic                    tfio_trig_tvalid_i,
    output logic                    tfio_trig_tready_o,
    input  logic                    tfio_pps_i,
    input  logic                    use_tfio_pps_i,
    output rackbus_pkg::cmd_word_t  spliced_o
);

    logic precapture;
    logic capture;

    rackbus_pkg::mode1data_t mode1data;
    rackbus_pkg::mode1type_t mode1type;
    logic                    mode1_holding;
    logic                    mode1_free;
    rackbus_pkg::runcmd_t    runcmd;
    logic                    runcmd_holding;
    logic                    runcmd_free;
    rackbus_pkg::trig_t      trig;
    logic                    trig_holding;
    logic                    trig_free;

    cmd_phase_gen i_phase (
        .sysclk_i     (sysclk_i),
        .rst_i        (rst_i),
        .sync_i       (sync_i),
        .precapture_o (precapture),
        .capture_o    (capture)
    );

    mode1_holder i_mode1 (
        .sysclk_i       (sysclk_i),
        .rst_i          (rst_i),
        .precapture_i   (precapture),
        .capture_i      (capture),
        .mode1_free_i   (mode1_free),
        .mode1_tdata_i  (mode1_tdata_i),
        .mode1_tuser_i  (mode1_tuser_i),
        .mode1_tvalid_i (mode1_tvalid_i),
        .fw_tdata_i     (tfio_fw_tdata_i),
        .fw_tvalid_i    (tfio_fw_tvalid_i),
        .fw_mark_i      (tfio_fw_mark_i),
        .mode1_tready_o (mode1_tready_o),
        .fw_tready_o    (tfio_fw_tready_o),
        .fw_marked_o    (tfio_fw_marked_o),
        .mode1data_o    (mode1data),
        .mode1type_o    (mode1type),
        .holding_o      (mode1_holding)
    );

    // run command idles as noop
    slot_holder #(
        .payload_t  (rackbus_pkg::runcmd_t),
        .idle_value (rackbus_pkg::RUNCMD_NOOP)
    ) i_runcmd (
        .sysclk_i     (sysclk_i),
        .rst_i        (rst_i),
        .precapture_i (precapture),
        .capture_i    (capture),
        .free_i       (runcmd_free),
        .tdata_i      (tfio_runcmd_tdata_i),
        .tvalid_i     (tfio_runcmd_tvalid_i),
        .tready_o     (tfio_runcmd_tready_o),
        .held_o       (runcmd),
        .holding_o    (runcmd_holding)
    );

    // idle trigger is all zero, its valid bit comes from holding_o
    slot_holder #(
        .payload_t  (rackbus_pkg::trig_t),
        .idle_value ('0)
    ) i_trig (
        .sysclk_i     (sysclk_i),
        .rst_i        (rst_i),
        .precapture_i (precapture),
        .capture_i    (capture),
        .free_i       (trig_free),
        .tdata_i      (tfio_trig_tdata_i),
        .tvalid_i     (tfio_trig_tvalid_i),
        .tready_o     (tfio_trig_tready_o),
        .held_o       (trig),
        .holding_o    (trig_holding)
    );

    cmd_splice i_splice (
        .sysclk_i         (sysclk_i),
        .rst_i            (rst_i),
        .capture_i        (capture),
        .command_i        (command_i),
        .command_locked_i (command_locked_i),
        .mode1data_i      (mode1data),
        .mode1type_i      (mode1type),
        .mode1_holding_i  (mode1_holding),
        .runcmd_i         (runcmd),
        .runcmd_holding_i (runcmd_holding),
        .trig_i           (trig),
        .trig_holding_i   (trig_holding),
        .tfio_pps_i       (tfio_pps_i),
        .use_tfio_pps_i   (use_tfio_pps_i),
        .mode1_free_o     (mode1_free),
        .runcmd_free_o    (runcmd_free),
        .trig_free_o      (trig_free),
        .spliced_o        (spliced_o)
    );

endmodule

// File: sim/turfio_cmd_properties.sv
`timescale 1ns/1ps

module turfio_cmd_properties (
    input logic       sysclk_i,
    input logic       rst_i,
    input logic       capture_i,
    input logic       mode1_tvalid_i,
    input logic       fw_tvalid_i,
    input logic [1:0] fw_mark_i,
    input logic       mode1_tready_o,
    input logic       fw_tready_o,
    input logic       fw_marked_o
);

    logic any_ack;

    assign any_ack = mode1_tready_o || fw_tready_o || fw_marked_o;

    // only the held source is acknowledged
    a_one_ack: assert property (@(posedge sysclk_i) disable iff (rst_i)
        $onehot0({mode1_tready_o, fw_tready_o, fw_marked_o}))
        else $error("more than one mode1 acknowledge in the same cycle");

    // acks come from the capture strobe, one cycle later
    a_ack_after_capture: assert property (@(posedge sysclk_i) disable iff (rst_i)
        any_ack |-> $past(capture_i))
        else $error("mode1 acknowledge outside the cycle after capture");

    a_mode1_valid: assert property (@(posedge sysclk_i) disable iff (rst_i)
        mode1_tready_o |-> mode1_tvalid_i)
        else $error("mode1 ready without valid");

    a_fw_valid: assert property (@(posedge sysclk_i) disable iff (rst_i)
        fw_tready_o |-> fw_tvalid_i)
        else $error("fw ready without valid");

    // a mark is held by its source until marked
    a_mark_held: assert property (@(posedge sysclk_i) disable iff (rst_i)
        fw_marked_o |-> (|fw_mark_i))
        else $error("fw marked without a mark pending");

endmodule

// File: sim/tb_turfio_cmd.sv
`timescale 1ns/1ps

module tb_turfio_cmd;

    logic                    sysclk_i;
    logic                    rst_i;
    logic                    sync_i;
    rackbus_pkg::cmd_word_t  command_i;
    logic                    command_locked_i;
    rackbus_pkg::mode1data_t mode1_tdata_i;
    rackbus_pkg::mode1type_t mode1_tuser_i;
    logic [2:0]              mode1_tdest_i;
    logic                    mode1_tvalid_i;
    logic                    mode1_tready_o;
    rackbus_pkg::mode1data_t tfio_fw_tdata_i;
    logic                    tfio_fw_tvalid_i;
    logic                    tfio_fw_tready_o;
    logic [1:0]              tfio_fw_mark_i;
    logic                    tfio_fw_marked_o;
    rackbus_pkg::runcmd_t    tfio_runcmd_tdata_i;
    logic                    tfio_runcmd_tvalid_i;
    logic                    tfio_runcmd_tready_o;
    rackbus_pkg::trig_t      tfio_trig_tdata_i;
    logic                    tfio_trig_tvalid_i;
    logic                    tfio_trig_tready_o;
    logic                    tfio_pps_i;
    logic                    use_tfio_pps_i;
    rackbus_pkg::cmd_word_t  spliced_o;

    integer seed = 32'h372b0319;
    int     errors = 0;
    int     checks = 0;

    turfio_cmd_top i_turfio_cmd_top (.*);

    // handshake checks on the mode1 holder
    bind mode1_holder turfio_cmd_properties i_mode1_props (
        .sysclk_i       (sysclk_i),
        .rst_i          (rst_i),
        .capture_i      (capture_i),
        .mode1_tvalid_i (mode1_tvalid_i),
        .fw_tvalid_i    (fw_tvalid_i),
        .fw_mark_i      (fw_mark_i),
        .mode1_tready_o (mode1_tready_o),
        .fw_tready_o    (fw_tready_o),
        .fw_marked_o    (fw_marked_o)
    );

    initial begin
        sysclk_i = 1'b0;
        forever #4 sysclk_i = ~sysclk_i;
    end

    // six tests, up to four frames each, 64 ns per frame, plus reset margin
    initial begin
        #(6 * 4 * 64 + 256);
        $display("watchdog expired, the tests did not finish in time");
        $display("TEST FAILED");
        $finish;
    end

    // packs a word from the backplane field layout
    function automatic rackbus_pkg::cmd_word_t make_word(
        input logic                    ign,
        input logic                    pps,
        input rackbus_pkg::runcmd_t    rc,
        input rackbus_pkg::mode1type_t mt,
        input rackbus_pkg::mode1data_t md,
        input logic                    tv,
        input rackbus_pkg::trig_t      tr
    );
        rackbus_pkg::cmd_word_t w;
        w = '0;
        w[rackbus_pkg::IGNORE_BIT] = ign;
        w[rackbus_pkg::PPS_BIT] = pps;
        w[rackbus_pkg::RUNCMD_LSB +: rackbus_pkg::RUNCMD_BITS] = rc;
        w[rackbus_pkg::MODE1TYPE_LSB +: rackbus_pkg::MODE1TYPE_BITS] = mt;
        w[rackbus_pkg::MODE1DATA_LSB +: rackbus_pkg::MODE1DATA_BITS] = md;
        w[rackbus_pkg::TRIG_VALID_BIT] = tv;
        w[rackbus_pkg::TRIG_LSB +: rackbus_pkg::TRIG_BITS] = tr;
        return w;
    endfunction

    function automatic rackbus_pkg::trig_t random_trig();
        integer r;
        r = $random(seed);
        return r[rackbus_pkg::TRIG_BITS-1:0];
    endfunction

    task automatic check_word(input string name, input rackbus_pkg::cmd_word_t got,
                              input rackbus_pkg::cmd_word_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("CHECK FAILED %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic check_ack(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("CHECK FAILED %s: got %h, expected %h", name, got, exp);
        end
    endtask

    // order: mode1, fw, marked, runcmd, trig
    task automatic check_acks(input logic [4:0] exp);
        check_ack("mode1_tready_o", mode1_tready_o, exp[4]);
        check_ack("tfio_fw_tready_o", tfio_fw_tready_o, exp[3]);
        check_ack("tfio_fw_marked_o", tfio_fw_marked_o, exp[2]);
        check_ack("tfio_runcmd_tready_o", tfio_runcmd_tready_o, exp[1]);
        check_ack("tfio_trig_tready_o", tfio_trig_tready_o, exp[0]);
    endtask

    // one frame from sync, E0 is the edge that sees sync_i
    // holders latch at E6, acks show after E7 and are gone after E8
    task automatic run_frame(input rackbus_pkg::cmd_word_t exp_word, input logic pps_pulse,
                             input logic [4:0] exp_ack);
        sync_i = 1'b1;
        @(posedge sysclk_i);
        #1;
        sync_i = 1'b0;
        repeat (2) @(posedge sysclk_i);
        // optional local pps, one cycle early in the frame
        #1;
        tfio_pps_i = pps_pulse;
        @(posedge sysclk_i);
        #1;
        tfio_pps_i = 1'b0;
        repeat (3) @(posedge sysclk_i);
        #1;
        check_word("spliced_o", spliced_o, exp_word);
        @(posedge sysclk_i);
        #1;
        check_acks(exp_ack);
        // transfer completes at E8, acks must be single cycle
        @(posedge sysclk_i);
        #1;
        check_acks(5'b00000);
    endtask

    task automatic report_test(input string name, input int errs_at_start);
        if (errors == errs_at_start) begin
            $display("%s: ok", name);
        end else begin
            $display("%s: %0d failed checks", name, errors - errs_at_start);
        end
    endtask

    task automatic test_unlocked_idle();
        int start;
        start = errors;
        command_locked_i = 1'b0;
        // garbage on an unlocked link must not leak through
        command_i = $random(seed);
        run_frame(32'h8000_0000, 1'b0, 5'b00000);
        report_test("unlocked_idle", start);
    endtask

    task automatic test_pass_through();
        int                     start;
        rackbus_pkg::trig_t     loc_trig;
        rackbus_pkg::cmd_word_t full;
        start = errors;
        loc_trig = random_trig();
        full = make_word(1'b0, 1'b1, 2'd2, rackbus_pkg::MODE1_FWU, 8'h5a, 1'b1, random_trig());
        command_locked_i = 1'b1;
        command_i = full;
        mode1_tdata_i = 8'h33;
        mode1_tuser_i = rackbus_pkg::MODE1_FWU;
        mode1_tvalid_i = 1'b1;
        tfio_runcmd_tdata_i = 2'd1;
        tfio_runcmd_tvalid_i = 1'b1;
        tfio_trig_tdata_i = loc_trig;
        tfio_trig_tvalid_i = 1'b1;
        run_frame(full, 1'b0, 5'b00000);
        // empty turf word, the pending items drain now
        command_i = '0;
        run_frame(make_word(1'b0, 1'b0, 2'd1, rackbus_pkg::MODE1_FWU, 8'h33, 1'b1, loc_trig),
                  1'b0, 5'b10011);
        mode1_tvalid_i = 1'b0;
        tfio_runcmd_tvalid_i = 1'b0;
        tfio_trig_tvalid_i = 1'b0;
        report_test("pass_through", start);
    endtask

    task automatic test_mode1_priority();
        int start;
        start = errors;
        command_i = '0;
        mode1_tdata_i = 8'hc3;
        mode1_tuser_i = 2'd2;
        mode1_tdest_i = 3'd5;
        mode1_tvalid_i = 1'b1;
        tfio_fw_tdata_i = 8'h7e;
        tfio_fw_tvalid_i = 1'b1;
        run_frame(make_word(1'b0, 1'b0, rackbus_pkg::RUNCMD_NOOP, 2'd2, 8'hc3, 1'b0, '0),
                  1'b0, 5'b10000);
        mode1_tvalid_i = 1'b0;
        // fw byte waited one frame behind the mode1 item
        run_frame(make_word(1'b0, 1'b0, rackbus_pkg::RUNCMD_NOOP, rackbus_pkg::MODE1_FWU,
                            8'h7e, 1'b0, '0), 1'b0, 5'b01000);
        tfio_fw_tvalid_i = 1'b0;
        report_test("mode1_priority", start);
    endtask

    task automatic test_mark();
        int start;
        start = errors;
        command_i = '0;
        tfio_fw_mark_i = 2'b11;
        run_frame(make_word(1'b0, 1'b0, rackbus_pkg::RUNCMD_NOOP, rackbus_pkg::MODE1_SPECIAL,
                            rackbus_pkg::MODE1_MARK0_FWU, 1'b0, '0), 1'b0, 5'b00100);
        tfio_fw_mark_i = 2'b00;
        report_test("mark", start);
    endtask

    task automatic test_runcmd_trig();
        int                 start;
        rackbus_pkg::trig_t loc_trig;
        start = errors;
        loc_trig = random_trig();
        // turf ignore set, runcmd noop, trigger valid clear
        // local items alone keep the spliced word usable
        command_i = make_word(1'b1, 1'b1, rackbus_pkg::RUNCMD_NOOP, rackbus_pkg::MODE1_FWU,
                              8'h11, 1'b0, random_trig());
        tfio_runcmd_tdata_i = 2'd3;
        tfio_runcmd_tvalid_i = 1'b1;
        tfio_trig_tdata_i = loc_trig;
        tfio_trig_tvalid_i = 1'b1;
        run_frame(make_word(1'b0, 1'b0, 2'd3, rackbus_pkg::MODE1_SPECIAL,
                            rackbus_pkg::MODE1_NOOP, 1'b1, loc_trig), 1'b0, 5'b00011);
        tfio_trig_tvalid_i = 1'b0;
        tfio_runcmd_tdata_i = 2'd1;
        // turf run command occupies the field
        command_i = make_word(1'b0, 1'b0, 2'd2, rackbus_pkg::MODE1_SPECIAL,
                              rackbus_pkg::MODE1_NOOP, 1'b0, '0);
        run_frame(command_i, 1'b0, 5'b00000);
        // withdraw the blocked run command before the next test
        tfio_runcmd_tvalid_i = 1'b0;
        report_test("runcmd_trig", start);
    endtask

    task automatic test_pps_source();
        int start;
        start = errors;
        command_i = '0;
        use_tfio_pps_i = 1'b1;
        run_frame(32'h4000_0000, 1'b1, 5'b00000);
        // remembered pps was cleared at the last capture
        run_frame(32'h0000_0000, 1'b0, 5'b00000);
        use_tfio_pps_i = 1'b0;
        command_i = 32'h4000_0000;
        run_frame(32'h4000_0000, 1'b1, 5'b00000);
        command_i = '0;
        run_frame(32'h0000_0000, 1'b1, 5'b00000);
        report_test("pps_source", start);
    endtask

    initial begin
        rst_i = 1'b1;
        sync_i = 1'b0;
        command_i = '0;
        command_locked_i = 1'b0;
        mode1_tdata_i = '0;
        mode1_tuser_i = '0;
        mode1_tdest_i = '0;
        mode1_tvalid_i = 1'b0;
        tfio_fw_tdata_i = '0;
        tfio_fw_tvalid_i = 1'b0;
        tfio_fw_mark_i = 2'b00;
        tfio_runcmd_tdata_i = '0;
        tfio_runcmd_tvalid_i = 1'b0;
        tfio_trig_tdata_i = '0;
        tfio_trig_tvalid_i = 1'b0;
        tfio_pps_i = 1'b0;
        use_tfio_pps_i = 1'b0;
        repeat (2) @(posedge sysclk_i);
        #1;
        rst_i = 1'b0;
        test_unlocked_idle();
        test_pass_through();
        test_mode1_priority();
        test_mark();
        test_runcmd_trig();
        test_pps_source();
        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// File: project.f
src/rackbus_pkg.sv
src/cmd_phase_gen.sv
src/mode1_holder.sv
src/slot_holder.sv
src/cmd_splice.sv
src/turfio_cmd_top.sv
sim/turfio_cmd_properties.sv
sim/tb_turfio_cmd.sv

// File: run_sim.sh
#!/usr/bin/env bash
# compile and run the testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    -f project.f \
    --top-module tb_turfio_cmd \
    -Mdir obj_dir -o sim_tb
if [ $? -ne 0 ]; then
    echo "compile failed"
    exit 1
fi

output=$(./obj_dir/sim_tb 2>&1)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -q "^TEST PASSED$"; then
    exit 0
fi
exit 1
